//--- logic/bank_mem.sv
/*
 * four-bank interleaved main memory
 * banks are picked by address bits 2:1, each bank rests for
 * BANK_CYCLES cycles after an access and stalls requests meanwhile
 * read data comes out of a two-stage register, two cycles after the read
 */
`timescale 1ns/1ps

module bank_mem #(
   parameter int BANK_CYCLES = 4
) (
   input  logic                               clk,
   input  logic                               reset,
   input  mem_sys_pkg::addr_t                 mem_addr,
   input  mem_sys_pkg::word_t                 mem_wdata,
   input  logic                               mem_wr,
   input  logic                               mem_rd,
   output mem_sys_pkg::word_t                 mem_rdata,
   output logic                               mem_stall,
   output logic [mem_sys_pkg::NUM_BANKS-1:0]  busy
);
   import mem_sys_pkg::*;

   localparam int BANK_WORDS = 8192;

   word_t       bank_store [NUM_BANKS][BANK_WORDS];
   logic [3:0]  timer [NUM_BANKS];
   bank_sel_t   bank;
   logic [12:0] row;
   logic        access;
   word_t       rd_q1;
   word_t       rd_q2;

   assign bank = mem_addr[2:1];
   assign row  = mem_addr[15:3];

   always_comb begin
      for (int i = 0; i < NUM_BANKS; i++)
         busy[i] = (timer[i] != 4'd0);
   end

   assign mem_stall = busy[bank];
   assign access    = (mem_rd || mem_wr) && !mem_stall;

   // per-bank rest timers
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < NUM_BANKS; i++)
            timer[i] <= 4'd0;
      end else begin
         for (int i = 0; i < NUM_BANKS; i++) begin
            if (access && (bank == bank_sel_t'(i)))
               timer[i] <= 4'(BANK_CYCLES);
            else if (timer[i] != 4'd0)
               timer[i] <= timer[i] - 4'd1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (access && mem_wr)
         bank_store[bank][row] <= mem_wdata;
      if (access && mem_rd)
         rd_q1 <= bank_store[bank][row];
      rd_q2 <= rd_q1;
   end

   assign mem_rdata = rd_q2;

   // a bank that was just used can't take the very next access
   a_bank_rest: assert property (@(posedge clk) disable iff (reset)
      access |=> !(access && (bank == $past(bank))));

endmodule

//--- logic/cache_array.sv
/*
 * direct-mapped cache storage
 * holds data words, tags, valid and dirty bits for every line
 * lookup is combinational, writes land on the clock edge
 * compare writes mark the line dirty, fill writes load a clean line
 */
`timescale 1ns/1ps

module cache_array (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 enable,
   input  logic                 comp,
   input  logic                 write,
   input  logic                 valid_in,
   input  mem_sys_pkg::index_t  index,
   input  mem_sys_pkg::offset_t offset,
   input  mem_sys_pkg::tag_t    tag_in,
   input  mem_sys_pkg::word_t   data_in,
   output logic                 hit,
   output logic                 dirty,
   output logic                 valid,
   output mem_sys_pkg::tag_t    tag_out,
   output mem_sys_pkg::word_t   data_out
);
   import mem_sys_pkg::*;

   word_t                data_mem [NUM_LINES][LINE_WORDS];
   tag_t                 tag_mem [NUM_LINES];
   logic [NUM_LINES-1:0] valid_bits;
   logic [NUM_LINES-1:0] dirty_bits;
   logic [1:0]           word_sel;
   logic                 wr_en;

   // byte bit is ignored here, the controller rejects odd addresses
   assign word_sel = offset[2:1];

   assign tag_out  = tag_mem[index];
   assign valid    = valid_bits[index];
   assign dirty    = dirty_bits[index];
   assign data_out = data_mem[index][word_sel];
   assign hit      = valid && (tag_out == tag_in);

   // compare writes only go through on a hit
   assign wr_en = enable && write && (!comp || hit);

   always_ff @(posedge clk) begin
      if (wr_en) begin
         data_mem[index][word_sel] <= data_in;
         if (!comp)
            tag_mem[index] <= tag_in;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         valid_bits <= '0;
         dirty_bits <= '0;
      end else if (wr_en) begin
         if (comp) begin
            dirty_bits[index] <= 1'b1;
         end else begin
            // fill from memory, line matches memory again
            valid_bits[index] <= valid_in;
            dirty_bits[index] <= 1'b0;
         end
      end
   end

   // the controller only issues compare writes for lines that hit
   a_comp_write_hit: assert property (@(posedge clk) disable iff (reset)
      (enable && comp && write) |-> hit);

endmodule

//--- logic/cache_ctrl.sv
/*
 * cache controller
 * accepts one request at a time, rejects odd addresses and rd+wr,
 * answers hits in one cycle, and on a miss writes back a dirty victim,
 * refills the line from banked memory with overlapped reads and fills,
 * then replays the request against the cache
 */
`timescale 1ns/1ps

module cache_ctrl (
   input  logic                 clk,
   input  logic                 reset,
   input  mem_sys_pkg::addr_t   addr,
   input  mem_sys_pkg::word_t   data_in,
   input  logic                 rd,
   input  logic                 wr,
   output mem_sys_pkg::word_t   data_out,
   output logic                 done,
   output logic                 stall,
   output logic                 cache_hit,
   output logic                 err,
   output logic                 c_enable,
   output logic                 c_comp,
   output logic                 c_write,
   output logic                 c_valid_in,
   output mem_sys_pkg::index_t  c_index,
   output mem_sys_pkg::offset_t c_offset,
   output mem_sys_pkg::tag_t    c_tag_in,
   output mem_sys_pkg::word_t   c_data_in,
   input  logic                 c_hit,
   input  logic                 c_dirty,
   input  logic                 c_valid,
   input  mem_sys_pkg::tag_t    c_tag_out,
   input  mem_sys_pkg::word_t   c_data_out,
   output mem_sys_pkg::addr_t   mem_addr,
   output mem_sys_pkg::word_t   mem_wdata,
   output logic                 mem_wr,
   output logic                 mem_rd,
   input  mem_sys_pkg::word_t   mem_rdata,
   input  logic                 mem_stall
);
   import mem_sys_pkg::*;

   ctrl_state_t state;
   ctrl_state_t state_next;
   addr_t       req_addr;
   word_t       req_data;
   logic        req_wr;
   logic        missed;
   logic [1:0]  wb_cnt;
   logic [1:0]  rd_cnt;
   logic [1:0]  fill_cnt;
   logic [1:0]  rd_pipe;
   logic        accept;
   logic        bad_req;
   logic        rd_take;
   logic        fill_now;
   tag_t        req_tag;
   index_t      req_index;
   offset_t     req_offset;

   assign accept     = (state == idle) && (rd || wr);
   assign bad_req    = addr[0] || (rd && wr);
   assign req_tag    = req_addr[15:11];
   assign req_index  = req_addr[10:3];
   assign req_offset = req_addr[2:0];
   assign stall      = (state != idle);

   // reads taken by memory, data returns two cycles later
   assign rd_take  = mem_rd && !mem_stall;
   assign fill_now = rd_pipe[1];

   always_ff @(posedge clk) begin
      if (accept) begin
         req_addr <= addr;
         req_data <= data_in;
         req_wr   <= wr;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state    <= idle;
         missed   <= 1'b0;
         wb_cnt   <= 2'd0;
         rd_cnt   <= 2'd0;
         fill_cnt <= 2'd0;
         rd_pipe  <= 2'b00;
      end else begin
         state   <= state_next;
         rd_pipe <= {rd_pipe[0], rd_take};
         if (accept) begin
            missed   <= 1'b0;
            wb_cnt   <= 2'd0;
            rd_cnt   <= 2'd0;
            fill_cnt <= 2'd0;
         end
         if ((state == compare) && !c_hit)
            missed <= 1'b1;
         if (mem_wr && !mem_stall)
            wb_cnt <= wb_cnt + 2'd1;
         if (rd_take)
            rd_cnt <= rd_cnt + 2'd1;
         if (fill_now)
            fill_cnt <= fill_cnt + 2'd1;
      end
   end

   always_comb begin
      state_next = state;
      done       = 1'b0;
      cache_hit  = 1'b0;
      err        = 1'b0;
      data_out   = '0;
      c_enable   = 1'b0;
      c_comp     = 1'b0;
      c_write    = 1'b0;
      c_valid_in = 1'b0;
      c_index    = req_index;
      c_offset   = req_offset;
      c_tag_in   = req_tag;
      c_data_in  = req_data;
      mem_addr   = '0;
      mem_wdata  = '0;
      mem_wr     = 1'b0;
      mem_rd     = 1'b0;

      // returning read data goes straight into the line
      if (fill_now) begin
         c_enable   = 1'b1;
         c_write    = 1'b1;
         c_valid_in = 1'b1;
         c_offset   = {fill_cnt, 1'b0};
         c_data_in  = mem_rdata;
      end

      case (state)
         idle: begin
            if (rd || wr)
               state_next = bad_req ? error : compare;
         end
         compare: begin
            c_enable = 1'b1;
            c_comp   = 1'b1;
            c_write  = req_wr && c_hit;
            if (c_hit) begin
               if (missed) begin
                  state_next = complete;
               end else begin
                  done       = 1'b1;
                  cache_hit  = 1'b1;
                  data_out   = c_data_out;
                  state_next = idle;
               end
            end else if (c_valid && c_dirty) begin
               state_next = writeback;
            end else begin
               state_next = alloc_req;
            end
         end
         writeback: begin
            // victim address comes from the stored tag
            c_enable  = 1'b1;
            c_offset  = {wb_cnt, 1'b0};
            mem_wr    = 1'b1;
            mem_addr  = {c_tag_out, req_index, wb_cnt, 1'b0};
            mem_wdata = c_data_out;
            if (!mem_stall && (wb_cnt == 2'd3))
               state_next = alloc_req;
         end
         alloc_req: begin
            mem_rd   = 1'b1;
            mem_addr = {req_tag, req_index, rd_cnt, 1'b0};
            if (!mem_stall && (rd_cnt == 2'd3))
               state_next = alloc_fill;
         end
         alloc_fill: begin
            if (fill_now && (fill_cnt == 2'd3))
               state_next = compare;
         end
         complete: begin
            c_enable   = 1'b1;
            c_comp     = 1'b1;
            done       = 1'b1;
            data_out   = c_data_out;
            state_next = idle;
         end
         error: begin
            done       = 1'b1;
            err        = 1'b1;
            state_next = idle;
         end
         default: state_next = idle;
      endcase
   end

   a_single_done: assert property (@(posedge clk) disable iff (reset)
      done |=> !done);

   a_mem_one_op: assert property (@(posedge clk) disable iff (reset)
      !(mem_wr && mem_rd));

endmodule

//--- logic/mem_sys_pkg.sv
/*
 * memory system shared definitions
 * address field widths, vector types for addresses, data and cache
 * fields, and the cache controller state encoding
 */
package mem_sys_pkg;

   // address split: tag | index | word | byte
   localparam int TAG_W     = 5;
   localparam int INDEX_W   = 8;
   localparam int OFFSET_W  = 3;
   localparam int NUM_LINES = 1 << INDEX_W;
   localparam int LINE_WORDS = 4;
   localparam int NUM_BANKS = 4;

   typedef logic [15:0]         addr_t;
   typedef logic [15:0]         word_t;
   typedef logic [TAG_W-1:0]    tag_t;
   typedef logic [INDEX_W-1:0]  index_t;
   typedef logic [OFFSET_W-1:0] offset_t;
   typedef logic [1:0]          bank_sel_t;

   // miss sequence runs writeback -> alloc_req -> alloc_fill -> compare
   typedef enum logic [2:0] {
      idle,
      compare,
      writeback,
      alloc_req,
      alloc_fill,
      complete,
      error
   } ctrl_state_t;

endpackage

//--- logic/mem_system.sv
/*
 * unified memory system top
 * direct-mapped write-back cache in front of a four-bank memory,
 * sequenced by the cache controller
 */
`timescale 1ns/1ps

module mem_system #(
   parameter int BANK_CYCLES = 4
) (
   input  logic               clk,
   input  logic               reset,
   input  mem_sys_pkg::addr_t addr,
   input  mem_sys_pkg::word_t data_in,
   input  logic               rd,
   input  logic               wr,
   output mem_sys_pkg::word_t data_out,
   output logic               done,
   output logic               stall,
   output logic               cache_hit,
   output logic               err
);
   import mem_sys_pkg::*;

   // controller to cache array
   logic    c_enable;
   logic    c_comp;
   logic    c_write;
   logic    c_valid_in;
   index_t  c_index;
   offset_t c_offset;
   tag_t    c_tag_in;
   tag_t    c_tag_out;
   word_t   c_data_in;
   word_t   c_data_out;
   logic    c_hit;
   logic    c_dirty;
   logic    c_valid;

   // controller to banked memory
   addr_t   mem_addr;
   word_t   mem_wdata;
   word_t   mem_rdata;
   logic    mem_wr;
   logic    mem_rd;
   logic    mem_stall;

   cache_ctrl i_ctrl (.*);

   cache_array i_cache (
      .clk, .reset,
      .enable(c_enable), .comp(c_comp), .write(c_write), .valid_in(c_valid_in),
      .index(c_index), .offset(c_offset), .tag_in(c_tag_in), .data_in(c_data_in),
      .hit(c_hit), .dirty(c_dirty), .valid(c_valid),
      .tag_out(c_tag_out), .data_out(c_data_out)
   );

   bank_mem #(.BANK_CYCLES(BANK_CYCLES)) i_mem (
      .clk, .reset,
      .mem_addr, .mem_wdata, .mem_wr, .mem_rd,
      .mem_rdata, .mem_stall, .busy()
   );

endmodule

//--- run.sh
#!/bin/sh
# build and run the memory system testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
   --top-module mem_system_tb \
   -f vlog.f \
   --Mdir obj_dir \
   -o mem_system_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/mem_system_sim
status=$?
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit $status
fi
exit 0

//--- tb/mem_system_tb.sv
/*
 * memory system testbench
 * runs a table of reads, writes and rejected requests through the
 * cache and banked memory, predicts hits with a tag model and data
 * with a flat reference memory
 */
`timescale 1ns/1ps

module mem_system_tb;
   import mem_sys_pkg::*;

   localparam int BANK_CYCLES = 4;
   localparam int MAX_ROWS    = 40;
   localparam int STALL_WAIT  = 50;
   localparam int DONE_WAIT   = 200;

   // table operations
   localparam int OP_RD   = 0;
   localparam int OP_WR   = 1;
   localparam int OP_BOTH = 2;

   logic  clk;
   logic  reset;
   addr_t addr;
   word_t data_in;
   logic  rd;
   logic  wr;
   word_t data_out;
   logic  done;
   logic  stall;
   logic  cache_hit;
   logic  err;

   // stimulus table, exp_tab is filled while the rows run
   int    op_tab   [MAX_ROWS];
   addr_t addr_tab [MAX_ROWS];
   word_t data_tab [MAX_ROWS];
   word_t exp_tab  [MAX_ROWS];
   int    num_rows;

   // flat memory image plus per-line tag model
   word_t ref_mem     [32768];
   tag_t  tag_model   [NUM_LINES];
   logic  valid_model [NUM_LINES];

   mem_system #(.BANK_CYCLES(BANK_CYCLES)) i_dut (.*);

   always #50 clk = ~clk;

   function automatic addr_t make_addr(input int tag, input int index, input int word);
      return addr_t'((tag << 11) | (index << 3) | (word << 1));
   endfunction

   task automatic check(input string name, input logic [15:0] got, input logic [15:0] exp);
      if (got !== exp) begin
         $display("error: %s is 0x%h, expected 0x%h", name, got, exp);
         $display("Done: errors found");
         $fatal(1, "mismatch, simulation stopped");
      end
   endtask

   task automatic give_up(input string what);
      $display("timeout: %s", what);
      $display("Done: errors found");
      $fatal(1, "timeout, simulation stopped");
   endtask

   task automatic add_row(input int op, input addr_t a);
      op_tab[num_rows]   = op;
      addr_tab[num_rows] = a;
      data_tab[num_rows] = word_t'($urandom);
      exp_tab[num_rows]  = '0;
      num_rows++;
   endtask

   task automatic build_table();
      // first touch of a line, then hits on it
      add_row(OP_WR, make_addr(1, 5, 0));
      add_row(OP_RD, make_addr(1, 5, 0));
      add_row(OP_WR, make_addr(1, 5, 1));
      // two tags fighting over index 5
      add_row(OP_WR, make_addr(2, 5, 0));
      add_row(OP_RD, make_addr(1, 5, 0));
      add_row(OP_RD, make_addr(1, 5, 1));
      add_row(OP_RD, make_addr(2, 5, 0));
      add_row(OP_WR, make_addr(1, 5, 1));
      add_row(OP_WR, make_addr(2, 5, 0));
      add_row(OP_RD, make_addr(1, 5, 1));
      add_row(OP_RD, make_addr(2, 5, 0));
      // rejected requests, then the line must still hit
      add_row(OP_RD, make_addr(2, 5, 0) | addr_t'(1));
      add_row(OP_RD, make_addr(2, 5, 0));
      add_row(OP_BOTH, make_addr(2, 5, 0));
      add_row(OP_RD, make_addr(2, 5, 0));
      // full line, evicted, read back out of order
      for (int w = 0; w < LINE_WORDS; w++)
         add_row(OP_WR, make_addr(4, 9, w));
      add_row(OP_WR, make_addr(5, 9, 0));
      add_row(OP_RD, make_addr(4, 9, 3));
      add_row(OP_RD, make_addr(4, 9, 0));
      add_row(OP_RD, make_addr(4, 9, 1));
      add_row(OP_RD, make_addr(4, 9, 2));
      // fresh lines at other indexes
      add_row(OP_WR, make_addr(3, 6, 2));
      add_row(OP_RD, make_addr(3, 6, 2));
      add_row(OP_WR, make_addr(0, 255, 3));
      add_row(OP_RD, make_addr(0, 255, 3));
      add_row(OP_WR, make_addr(31, 0, 1));
      add_row(OP_RD, make_addr(31, 0, 1));
   endtask

   task automatic run_row(input int r);
      int    cycles;
      logic  exp_err;
      logic  exp_hit;
      addr_t a;
      a       = addr_tab[r];
      exp_err = a[0] || (op_tab[r] == OP_BOTH);
      exp_hit = 1'b0;
      if (!exp_err) begin
         exp_hit = valid_model[a[10:3]] && (tag_model[a[10:3]] == a[15:11]);
         tag_model[a[10:3]]   = a[15:11];
         valid_model[a[10:3]] = 1'b1;
         if (op_tab[r] == OP_WR)
            ref_mem[a[15:1]] = data_tab[r];
         exp_tab[r] = ref_mem[a[15:1]];
      end

      cycles = 0;
      while (stall) begin
         @(posedge clk);
         #1;
         cycles++;
         if (cycles > STALL_WAIT)
            give_up("stall stayed high before a new request");
      end

      addr    = a;
      data_in = data_tab[r];
      rd      = (op_tab[r] != OP_WR);
      wr      = (op_tab[r] != OP_RD);
      @(posedge clk);
      #1;
      rd = 1'b0;
      wr = 1'b0;

      // stall must cover the whole request up to its done
      cycles = 1;
      while (!done) begin
         check("stall", 16'(stall), 16'd1);
         @(posedge clk);
         #1;
         cycles++;
         if (cycles > DONE_WAIT)
            give_up("request got no done within 200 cycles");
      end
      check("stall", 16'(stall), 16'd1);
      check("err", 16'(err), 16'(exp_err));
      check("cache_hit", 16'(cache_hit), 16'(exp_hit));
      if (exp_hit || exp_err)
         check("latency", 16'(cycles), 16'd1);
      else
         check("miss_longer_than_hit", 16'(cycles > 1), 16'd1);
      if (!exp_err && (op_tab[r] == OP_RD))
         check("data_out", data_out, exp_tab[r]);

      // one done per request, then back to idle
      @(posedge clk);
      #1;
      check("done", 16'(done), 16'd0);
      check("stall", 16'(stall), 16'd0);
   endtask

   initial begin
      clk      = 1'b0;
      reset    = 1'b1;
      rd       = 1'b0;
      wr       = 1'b0;
      addr     = '0;
      data_in  = '0;
      num_rows = 0;
      void'($urandom(57));
      for (int i = 0; i < NUM_LINES; i++) begin
         valid_model[i] = 1'b0;
         tag_model[i]   = '0;
      end
      build_table();

      repeat (8) @(posedge clk);
      #1;
      reset = 1'b0;
      check("done", 16'(done), 16'd0);
      check("err", 16'(err), 16'd0);
      check("cache_hit", 16'(cache_hit), 16'd0);
      check("stall", 16'(stall), 16'd0);

      for (int r = 0; r < num_rows; r++)
         run_row(r);

      $display("Done: no errors");
      $finish;
   end

endmodule

//--- vlog.f
// package first, then RTL bottom-up, then testbench
logic/mem_sys_pkg.sv
logic/cache_array.sv
logic/bank_mem.sv
logic/cache_ctrl.sv
logic/mem_system.sv
tb/mem_system_tb.sv
